// File: dv/iso14443a_model.svh
/*
  Cycle-level reference model of the ISO 14443-A front end.
  Included in the testbench module body. model_step advances the model by
  one falling clock edge from the inputs seen at that edge, and the m_
  outputs are then compared with the DUT.
*/
`ifndef ISO14443A_MODEL_SVH
`define ISO14443A_MODEL_SVH

// pause detector state, the runs count consecutive samples of one kind
bit m_shaped;
bit m_shaped_d;
bit m_active;
int m_weak_run;
int m_zero_run;
int m_nonzero_run;

// timebase and tag detector state, m_hist[0] is the newest delayed sample
int m_phase;
int m_pause_time;
int m_hist[4];
int m_window;
int m_pos_max;
int m_neg_max;
bit m_tag_bit;

// serializer state and the compared outputs
bit [3:0] m_reader_nib;
bit [3:0] m_tag_nib;
bit [7:0] m_byte;
bit m_ssp_clk;
bit m_ssp_frame;
bit m_ssp_din;
bit m_carrier_en;

task automatic model_step(input bit rst, input int adc, input int mode, input int thr,
                          input bit dout);
    bit shaped, active, tag, start, stop, sniff, listen;
    bit [3:0] rn, tn;
    bit [7:0] by;
    int phase, slot, pt, win, filt, step, clk_p, frm_p, rise, fall;
    begin
        // everything below reacts to the state before this edge
        shaped = m_shaped;
        active = m_active;
        tag    = m_tag_bit;
        start  = m_shaped_d && !m_shaped;
        stop   = !m_shaped_d && m_shaped;
        phase  = m_phase;
        slot   = phase % 16;
        pt     = m_pause_time;
        win    = m_window;
        rn     = m_reader_nib;
        tn     = m_tag_nib;
        by     = m_byte;
        sniff  = (mode == mode_sniffer);
        listen = (mode == mode_reader_listen);

        // slope: twice the oldest plus the next, minus twice current plus newest delayed
        filt = 2 * m_hist[3] + m_hist[2] - 2 * adc - m_hist[0];
        // the sample history has no reset, it shifts during reset too
        m_hist[3] = m_hist[2];
        m_hist[2] = m_hist[1];
        m_hist[1] = m_hist[0];
        m_hist[0] = adc;

        if (rst)
        begin
            m_shaped = 1;
            m_shaped_d = 1;
            m_active = 0;
            m_weak_run = 0;
            m_zero_run = 0;
            m_nonzero_run = 0;
            m_phase = 0;
            m_pause_time = edge_time_none;
            m_window = listen_window_start;
            m_pos_max = 0;
            m_neg_max = 0;
            m_tag_bit = 0;
            m_reader_nib = 0;
            m_tag_nib = 0;
            m_byte = 0;
            m_ssp_clk = 0;
            m_ssp_frame = 0;
            m_ssp_din = 0;
            m_carrier_en = 0;
        end
        else
        begin
            // --------------------------------------------------
            // reader pauses and activity
            // --------------------------------------------------
            m_shaped_d = shaped;
            if (adc >= level_high)
                m_shaped = 1;
            else if (adc < level_low)
                m_shaped = 0;
            // the 4096th weak sample in a row restores the unmodulated level
            if (adc >= field_present_level)
                m_weak_run = 0;
            else
            begin
                m_weak_run = m_weak_run + 1;
                if (m_weak_run == field_loss_cycles)
                begin
                    m_weak_run = 0;
                    m_shaped = 1;
                end
            end
            if (adc == 0)
            begin
                m_nonzero_run = 0;
                if (m_zero_run < deep_entry_cycles)
                    m_zero_run = m_zero_run + 1;
                if (m_zero_run == deep_entry_cycles)
                    m_active = 1;
            end
            else
            begin
                m_zero_run = 0;
                if (m_nonzero_run < deep_exit_cycles)
                    m_nonzero_run = m_nonzero_run + 1;
                if (m_nonzero_run == deep_exit_cycles)
                    m_active = 0;
            end

            // --------------------------------------------------
            // timebase, window and tag bit
            // --------------------------------------------------
            step = 1;
            if (start)
                m_pause_time = slot;
            if (sniff && active && slot == phase_adjust_slot)
            begin
                step = (pt == 1) ? 2 : ((pt == 0) ? 0 : 1);
                m_pause_time = edge_time_none;
            end
            m_phase = (phase + step) % 128;

            if (listen)
                m_window = listen_window_start;
            else if (sniff && stop && active)
                m_window = (slot + 16 - int'(sniff_window_offset)) % 16;

            if (slot == win)
            begin
                m_tag_bit = (m_pos_max > thr) && (m_neg_max < -thr);
                m_pos_max = 0;
                m_neg_max = 0;
            end
            else if (filt > 0)
            begin
                if (filt > m_pos_max)
                    m_pos_max = filt;
            end
            else if (filt < m_neg_max)
                m_neg_max = filt;

            // --------------------------------------------------
            // serial link and carrier
            // --------------------------------------------------
            if (slot == 0)
            begin
                m_reader_nib = {rn[2:0], shaped};
                m_tag_nib = {tn[2:0], tag};
            end
            if (sniff && phase % 64 == 63)
                m_byte = {rn, active ? 4'b0000 : tn};
            else if (sniff && phase % 8 == 0 && phase % 64 != 0)
                m_byte = by << 1;

            clk_p = sniff ? 8 : 16;
            frm_p = sniff ? 64 : 128;
            rise  = sniff ? 0 : 7;
            fall  = sniff ? 8 : 23;
            if (phase % clk_p == 0)
                m_ssp_clk = 1;
            else if (phase % clk_p == clk_p / 2)
                m_ssp_clk = 0;
            if (phase % frm_p == rise)
                m_ssp_frame = 1;
            else if (phase % frm_p == fall)
                m_ssp_frame = 0;

            if (sniff)
                m_ssp_din = by[7];
            else if (listen)
                m_ssp_din = (slot == 0) ? tag : m_ssp_din;
            else
                m_ssp_din = 0;

            m_carrier_en = (mode == mode_reader_mod) ? !dout : listen;
        end
    end
endtask

`endif

// File: dv/tb_hi_iso14443a.sv
/*
  Testbench for the ISO 14443-A front end top level.
  Runs six phases of random samples (pauses, noise, tag bursts) in the
  idle, reader modulation, reader listen and sniffer modes, and compares
  every output of the DUT with the included model each cycle.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_hi_iso14443a;
    import iso14443a_rf_pkg::*;
    import iso14443a_link_pkg::*;

    localparam int reset_cycles   = 5;
    localparam int num_phases     = 6;
    localparam int phase_cycles   = 6000;
    // all phases plus a margin for reset and the gaps between phases
    localparam int timeout_cycles = num_phases * phase_cycles + 4000;

    logic ck_1356meg, fdt_reset, ssp_dout;
    adc_sample_t adc_d;
    mode_t mod_type;
    logic [10:0] edge_detect_threshold;
    logic ssp_din, ssp_frame, ssp_clk, adc_clk, pwr_lo, pwr_hi;
    logic pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4, debug;

    integer seed;
    int pause_left, burst_left;
    int checks, errors, cycle_count;
    bit checking;

    `include "iso14443a_model.svh"

    hi_iso14443a UUT (
        .ck_1356meg (ck_1356meg), .fdt_reset (fdt_reset), .adc_d (adc_d),
        .mod_type (mod_type), .edge_detect_threshold (edge_detect_threshold),
        .ssp_dout (ssp_dout), .ssp_din (ssp_din), .ssp_frame (ssp_frame),
        .ssp_clk (ssp_clk), .adc_clk (adc_clk), .pwr_lo (pwr_lo), .pwr_hi (pwr_hi),
        .pwr_oe1 (pwr_oe1), .pwr_oe2 (pwr_oe2), .pwr_oe3 (pwr_oe3), .pwr_oe4 (pwr_oe4),
        .debug (debug)
    );

    always #50 ck_1356meg = ~ck_1356meg;

    // the model sees the same falling edge and inputs as the DUT
    always @(negedge ck_1356meg)
        model_step(fdt_reset, int'(adc_d), int'(mod_type), int'(edge_detect_threshold),
                   ssp_dout);

    // --------------------------------------------------
    // comparison, early in each clock phase
    // --------------------------------------------------
    task automatic compare(input string name, input logic got, input bit exp);
        begin
            checks = checks + 1;
            assert (got === exp)
            else
            begin
                $display("** Error at %0t ns: %s is %b, model expects %b", $time, name, got, exp);
                errors = errors + 1;
            end
        end
    endtask

    always @(posedge ck_1356meg)
    begin
        #10;
        if (checking)
        begin
            compare("ssp_din", ssp_din, m_ssp_din);
            compare("ssp_clk", ssp_clk, m_ssp_clk);
            compare("ssp_frame", ssp_frame, m_ssp_frame);
            // pwr_hi is the clock gated by the carrier enable, and the clock is high here
            compare("pwr_hi", pwr_hi, m_carrier_en);
            compare("adc_clk", adc_clk, 1'b1);
            compare("debug", debug, m_phase[3]);
            // the low-frequency drive and the load switches stay off in every kept mode
            compare("pwr_lo", pwr_lo, 1'b0);
            compare("pwr_oe1", pwr_oe1, 1'b0);
            compare("pwr_oe2", pwr_oe2, 1'b0);
            compare("pwr_oe3", pwr_oe3, 1'b0);
            compare("pwr_oe4", pwr_oe4, 1'b0);
        end
    end

    // in the low clock phase the gated carrier and the sampler clock are both low
    always @(negedge ck_1356meg)
    begin
        #10;
        if (checking)
        begin
            compare("pwr_hi", pwr_hi, 1'b0);
            compare("adc_clk", adc_clk, 1'b0);
        end
    end

    always @(posedge ck_1356meg)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("the run timed out after %0d cycles without finishing", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // any code other than 0, 3 and 4 is idle, so the kept codes move to 8, 11 and 12
    function automatic mode_t pick_idle_code(input int r);
        int v;
        begin
            v = r & 15;
            if (v == 0 || v == 3 || v == 4)
                v = v + 8;
            return mode_t'(v);
        end
    endfunction

    // carrier with noise, random runs of zeros and 16-cycle load-modulation bursts
    function automatic int make_sample(input bit pauses_on, input bit bursts_on,
                                       input int carrier, input int r);
        int s;
        begin
            if (pause_left > 0)
            begin
                s = 0;
                pause_left = pause_left - 1;
            end
            else if (burst_left > 0)
            begin
                // loaded for the first half, giving one falling and one rising step
                s = ((burst_left > 8) ? carrier - 40 : carrier) + (r & 7);
                burst_left = burst_left - 1;
            end
            else
            begin
                s = carrier + (r & 7);
                // pauses of 2 to 17 cycles, the longer ones mark the reader active
                if (pauses_on && ((r >> 4) & 63) == 0)
                    pause_left = 2 + ((r >> 10) & 15);
                else if (bursts_on && ((r >> 4) & 31) == 1)
                    burst_left = 16;
            end
            return s;
        end
    endfunction

    task automatic drive_cycle(input int id, input int i);
        int r;
        int s;
        begin
            r = $random(seed);
            ssp_dout <= r[16];
            if (i % 500 == 0)
                edge_detect_threshold <= 11'(20 + ((r >> 20) & 127));
            case (id)
                1: if (i % 1000 == 0) mod_type <= pick_idle_code(r >> 24);
                2: mod_type <= mode_reader_mod;
                3: mod_type <= mode_reader_listen;
                // phase 6 ends in sniffer mode so the restored reader level is serialized
                6: mod_type <= (i < 5400) ? mode_reader_listen : mode_sniffer;
                default: mod_type <= mode_sniffer;
            endcase
            // phase 6 holds a weak field between the trigger levels right after a long pause
            if (id == 6 && i >= 1000 && i < 1012)
                s = 0;
            else if (id == 6 && i >= 1012 && i < 5700)
                s = int'(level_low) + ((r >> 8) & 7);
            else
                s = make_sample(id == 1 || id == 2 || id == 5 || (id == 6 && i < 1000),
                                id != 2, (id == 6) ? 200 : 128, r);
            adc_d <= adc_sample_t'(s);
        end
    endtask

    task automatic run_phase(input int id, input string name);
        int i;
        int start_checks;
        int start_errors;
        begin
            start_checks = checks;
            start_errors = errors;
            for (i = 0; i < phase_cycles; i++)
            begin
                @(posedge ck_1356meg);
                drive_cycle(id, i);
            end
            @(negedge ck_1356meg);
            $display("phase %0d %s: %0d checks, %0d errors", id, name,
                     checks - start_checks, errors - start_errors);
        end
    endtask

    initial
    begin
        seed = 32'hba480c17;
        ck_1356meg = 1'b0;
        fdt_reset = 1'b1;
        adc_d = 8'd128;
        mod_type = 4'd1;
        edge_detect_threshold = 11'd60;
        ssp_dout = 1'b0;
        checks = 0;
        errors = 0;
        cycle_count = 0;
        pause_left = 0;
        burst_left = 0;
        checking = 1'b0;
        repeat (reset_cycles) @(posedge ck_1356meg);
        fdt_reset <= 1'b0;
        checking = 1'b1;

        run_phase(1, "idle");
        run_phase(2, "reader modulation");
        run_phase(3, "reader listen");
        run_phase(4, "sniffer without pauses");
        run_phase(5, "sniffer with pauses");
        run_phase(6, "weak field in reader listen");

        $display("%0d phases, %0d checks, %0d errors", num_phases, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/iso14443a_rf_pkg.sv
source/iso14443a_link_pkg.sv
source/reader_sense_if.sv
source/reader_pause_detector.sv
source/carrier_timebase.sv
source/tag_modulation_detector.sv
source/ssp_serializer.sv
source/hi_iso14443a.sv
+incdir+dv
dv/tb_hi_iso14443a.sv

// File: source/carrier_timebase.sv
/*
  Free-running 7-bit carrier-cycle counter that frames the serial link.
  While sniffing an active reader it shifts its own phase by one cycle
  per pause so that sampling stays clear of the reader's edges.
*/
`timescale 1ns/10ps
`default_nettype none

module carrier_timebase (
    input  logic                        ck_1356meg,
    input  logic                        fdt_reset,
    input  iso14443a_link_pkg::mode_t   mod_type,
    reader_sense_if.sink                sense,
    output iso14443a_link_pkg::phase_t  phase
);
    import iso14443a_link_pkg::*;

    // slot at which the last pause started
    slot_t pause_time;
    logic  adjust;

    assign adjust = (mod_type == mode_sniffer) && sense.reader_active
                    && (phase[3:0] == phase_adjust_slot);

    always_ff @(negedge ck_1356meg)
    begin
        if (fdt_reset)
        begin
            phase      <= '0;
            pause_time <= edge_time_none;
        end
        else
        begin
            if (sense.pause_start)
                pause_time <= phase[3:0];

            if (adjust)
            begin
                // pause came right after sampling, sample earlier next time
                if (pause_time == 4'd1)
                    phase <= phase + 7'd2;
                // pause came right before sampling, so hold and sample later
                else if (pause_time == 4'd0)
                    phase <= phase;
                else
                    phase <= phase + 7'd1;
                // one adjustment per pause, this wins over a capture above
                pause_time <= edge_time_none;
            end
            else
                phase <= phase + 7'd1;
        end
    end

endmodule

`default_nettype wire

// File: source/hi_iso14443a.sv
/*
  Top level of the ISO 14443-A front end between the RF sampler and the
  host. Wires the pause detector, timebase, tag detector and serializer,
  and drives the antenna: carrier dropped on host data in reader
  modulation, always on in reader listen, off otherwise.
*/
`timescale 1ns/10ps
`default_nettype none

module hi_iso14443a (
    input  logic                          ck_1356meg,
    input  logic                          fdt_reset,
    input  iso14443a_rf_pkg::adc_sample_t adc_d,
    input  iso14443a_link_pkg::mode_t     mod_type,
    input  logic [10:0]                   edge_detect_threshold,
    input  logic                          ssp_dout,
    output logic                          ssp_din,
    output logic                          ssp_frame,
    output logic                          ssp_clk,
    output logic                          adc_clk,
    output logic                          pwr_lo,
    output logic                          pwr_hi,
    output logic                          pwr_oe1,
    output logic                          pwr_oe2,
    output logic                          pwr_oe3,
    output logic                          pwr_oe4,
    output logic                          debug
);
    import iso14443a_link_pkg::*;

    reader_sense_if sense ();

    phase_t phase;
    logic   tag_bit;
    logic   carrier_en;

    // --------------------------------------------------
    // receive path and serial link
    // --------------------------------------------------
    reader_pause_detector u_pause (
        .ck_1356meg (ck_1356meg),
        .fdt_reset  (fdt_reset),
        .adc_d      (adc_d),
        .sense      (sense)
    );

    carrier_timebase u_timebase (
        .ck_1356meg (ck_1356meg),
        .fdt_reset  (fdt_reset),
        .mod_type   (mod_type),
        .sense      (sense),
        .phase      (phase)
    );

    tag_modulation_detector u_tag (
        .ck_1356meg            (ck_1356meg),
        .fdt_reset             (fdt_reset),
        .mod_type              (mod_type),
        .adc_d                 (adc_d),
        .edge_detect_threshold (edge_detect_threshold),
        .sense                 (sense),
        .phase                 (phase),
        .tag_bit               (tag_bit)
    );

    ssp_serializer u_ssp (
        .ck_1356meg (ck_1356meg),
        .fdt_reset  (fdt_reset),
        .mod_type   (mod_type),
        .sense      (sense),
        .phase      (phase),
        .tag_bit    (tag_bit),
        .ssp_din    (ssp_din),
        .ssp_clk    (ssp_clk),
        .ssp_frame  (ssp_frame)
    );

    // --------------------------------------------------
    // antenna drive
    // --------------------------------------------------
    always_ff @(negedge ck_1356meg)
    begin
        if (fdt_reset)
            carrier_en <= 1'b0;
        else if (mod_type == mode_reader_mod)
            // a 1 from the host is a pause in the field
            carrier_en <= ~ssp_dout;
        else if (mod_type == mode_reader_listen)
            carrier_en <= 1'b1;
        else
            carrier_en <= 1'b0;
    end

    // enable changes on the falling edge, so the gated clock stays clean
    assign pwr_hi  = ck_1356meg & carrier_en;
    assign adc_clk = ck_1356meg;

    // low-frequency drive and load switches are unused in these modes
    assign pwr_lo  = 1'b0;
    assign pwr_oe1 = 1'b0;
    assign pwr_oe2 = 1'b0;
    assign pwr_oe3 = 1'b0;
    assign pwr_oe4 = 1'b0;

    assign debug = phase[3];

endmodule

`default_nettype wire

// File: source/iso14443a_link_pkg.sv
/*
  Mode codes and serial-link timing for the ISO 14443-A front end.
  The mode word comes from the host; the phase and slot types describe
  the 128-cycle carrier timebase that the serial link is framed on.
*/
`default_nettype none

package iso14443a_link_pkg;

    typedef logic [3:0] mode_t;
    // carrier-cycle count, one full byte transfer at the slow rate
    typedef logic [6:0] phase_t;
    // position inside one 16-cycle bit slot
    typedef logic [3:0] slot_t;

    // the kept modes, anything else behaves as idle
    localparam mode_t mode_sniffer       = 4'd0;
    localparam mode_t mode_reader_listen = 4'd3;
    localparam mode_t mode_reader_mod    = 4'd4;

    // --------------------------------------------------
    // window and timebase alignment
    // --------------------------------------------------
    localparam slot_t listen_window_start = 4'd4;
    localparam slot_t sniff_window_offset = 4'd3;
    localparam slot_t phase_adjust_slot   = 4'd13;
    // stored pause time meaning no pause seen since the last adjustment
    localparam slot_t edge_time_none      = 4'd8;

    // serial clock and frame periods in carrier cycles
    localparam int ssp_clk_fast_period = 8;
    localparam int ssp_clk_slow_period = 16;
    localparam int frame_fast_period   = 64;
    localparam int frame_slow_period   = 128;

    // frame high ranges, rise and fall positions within the frame period
    localparam int sniff_frame_rise = 0;
    localparam int sniff_frame_fall = 8;
    localparam int frame_rise       = 7;
    localparam int frame_fall       = 23;

endpackage

`default_nettype wire

// File: source/iso14443a_rf_pkg.sv
/*
  RF-side definitions for the ISO 14443-A front end.
  Holds the sampler word and filter types, the Schmitt trigger levels,
  the field-loss limit and the sample counts for reader activity.
  Modules import it inside their body; ports use scoped names.
*/
`default_nettype none

package iso14443a_rf_pkg;

    // one word from the 8-bit RF sampler
    typedef logic [7:0] adc_sample_t;

    // signed output of the derivative filter, also used for slope maxima
    typedef logic signed [10:0] filtered_t;

    // --------------------------------------------------
    // Schmitt trigger levels on the sampled carrier
    // --------------------------------------------------
    // a sample at or above level_high sets the shaped reader signal
    localparam adc_sample_t level_high = 8'd16;
    // a sample below level_low clears it
    localparam adc_sample_t level_low = 8'd8;

    // below this level the field counts as weak
    localparam adc_sample_t field_present_level = 8'd192;
    // this many weak samples in a row force the shaped signal back high
    localparam int field_loss_cycles = 4096;

    // zero samples in a row that mark a reader as actively pausing
    localparam int deep_entry_cycles = 8;
    // non-zero samples in a row after which the reader counts as idle
    localparam int deep_exit_cycles = 256;

endpackage

`default_nettype wire

// File: source/reader_pause_detector.sv
/*
  Shapes the reader's 100 % pauses out of the sampled carrier.
  A Schmitt trigger avoids false edges on slow amplitude changes, a long
  weak field restores the unmodulated level, and runs of zero and
  non-zero samples tell whether a reader is actively sending.
*/
`timescale 1ns/10ps
`default_nettype none

module reader_pause_detector (
    input  logic                          ck_1356meg,
    input  logic                          fdt_reset,
    input  iso14443a_rf_pkg::adc_sample_t adc_d,
    reader_sense_if.source                sense
);
    import iso14443a_rf_pkg::*;

    logic        shaped;
    logic        shaped_d;
    logic [11:0] low_cnt;
    logic [2:0]  deep_cnt;
    logic [7:0]  idle_cnt;
    logic        reader_active;

    // --------------------------------------------------
    // hysteresis and field-loss recovery
    // --------------------------------------------------
    always_ff @(negedge ck_1356meg)
    begin
        if (fdt_reset)
        begin
            shaped   <= 1'b1;
            shaped_d <= 1'b1;
            low_cnt  <= '0;
        end
        else
        begin
            shaped_d <= shaped;
            // between the two levels the previous decision holds
            if (adc_d >= level_high)
                shaped <= 1'b1;
            else if (adc_d < level_low)
                shaped <= 1'b0;

            // a field that stays weak this long is treated as unmodulated,
            // so this overrides the trigger above
            if (adc_d >= field_present_level)
                low_cnt <= '0;
            else if (int'(low_cnt) == field_loss_cycles - 1)
            begin
                low_cnt <= '0;
                shaped  <= 1'b1;
            end
            else
                low_cnt <= low_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // reader activity from zero and non-zero runs
    // --------------------------------------------------
    always_ff @(negedge ck_1356meg)
    begin
        if (fdt_reset)
        begin
            deep_cnt      <= '0;
            idle_cnt      <= '0;
            reader_active <= 1'b0;
        end
        else if (adc_d == '0)
        begin
            idle_cnt <= '0;
            // the count saturates, every further zero keeps the flag set
            if (int'(deep_cnt) == deep_entry_cycles - 1)
                reader_active <= 1'b1;
            else
                deep_cnt <= deep_cnt + 1'b1;
        end
        else
        begin
            deep_cnt <= '0;
            if (int'(idle_cnt) == deep_exit_cycles - 1)
                reader_active <= 1'b0;
            else
                idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign sense.shaped        = shaped;
    assign sense.pause_start   = shaped_d & ~shaped;
    assign sense.pause_end     = ~shaped_d & shaped;
    assign sense.reader_active = reader_active;

endmodule

`default_nettype wire

// File: source/reader_sense_if.sv
/*
  Shaped reader signal with its edge pulses and the reader-activity flag.
  Driven by the pause detector and read by the timebase, the tag
  modulation detector and the serializer.
*/
`timescale 1ns/10ps
`default_nettype none

interface reader_sense_if;

    logic shaped;
    // one-cycle pulses on the falling and rising edge of shaped
    logic pause_start;
    logic pause_end;
    // a reader is pausing the field deeply
    logic reader_active;

    modport source (output shaped, output pause_start, output pause_end, output reader_active);
    modport sink (input shaped, input pause_start, input pause_end, input reader_active);

endinterface

`default_nettype wire

// File: source/ssp_serializer.sv
/*
  Serial link towards the host.
  While sniffing, four reader samples and four tag bits go out as one
  byte per 64 cycles at the fast rate; in reader listen the recovered tag
  bit goes out once per slot. Also generates the serial clock and frame.
*/
`timescale 1ns/10ps
`default_nettype none

module ssp_serializer (
    input  logic                        ck_1356meg,
    input  logic                        fdt_reset,
    input  iso14443a_link_pkg::mode_t   mod_type,
    reader_sense_if.sink                sense,
    input  iso14443a_link_pkg::phase_t  phase,
    input  logic                        tag_bit,
    output logic                        ssp_din,
    output logic                        ssp_clk,
    output logic                        ssp_frame
);
    import iso14443a_link_pkg::*;

    logic [3:0] reader_nib;
    logic [3:0] tag_nib;
    logic [7:0] byte_q;
    logic       sniffing;
    logic       slot_start;
    int         pos;

    assign sniffing   = (mod_type == mode_sniffer);
    assign slot_start = (phase[3:0] == 4'd0);
    assign pos        = int'(phase);

    // --------------------------------------------------
    // sampling and byte assembly
    // --------------------------------------------------
    always_ff @(negedge ck_1356meg)
    begin
        if (fdt_reset)
        begin
            reader_nib <= '0;
            tag_nib    <= '0;
            byte_q     <= '0;
        end
        else
        begin
            if (slot_start)
            begin
                reader_nib <= {reader_nib[2:0], sense.shaped};
                tag_nib    <= {tag_nib[2:0], tag_bit};
            end

            if (sniffing)
            begin
                // while a reader sends, the tag nibble carries no data
                if (phase[5:0] == 6'd63)
                    byte_q <= {reader_nib, sense.reader_active ? 4'b0000 : tag_nib};
                // a freshly loaded byte keeps its first bit for one period
                else if (phase[2:0] == 3'd0 && phase[5:0] != 6'd0)
                    byte_q <= {byte_q[6:0], 1'b0};
            end
        end
    end

    // --------------------------------------------------
    // serial clock, frame and data selection
    // --------------------------------------------------
    always_ff @(negedge ck_1356meg)
    begin
        if (fdt_reset)
        begin
            ssp_clk   <= 1'b0;
            ssp_frame <= 1'b0;
            ssp_din   <= 1'b0;
        end
        else
        begin
            if (sniffing)
            begin
                // fast rate, clock high for the first half of each period
                if (pos % ssp_clk_fast_period == 0)
                    ssp_clk <= 1'b1;
                else if (pos % ssp_clk_fast_period == ssp_clk_fast_period / 2)
                    ssp_clk <= 1'b0;
                if (pos % frame_fast_period == sniff_frame_rise)
                    ssp_frame <= 1'b1;
                else if (pos % frame_fast_period == sniff_frame_fall)
                    ssp_frame <= 1'b0;
            end
            else
            begin
                if (pos % ssp_clk_slow_period == 0)
                    ssp_clk <= 1'b1;
                else if (pos % ssp_clk_slow_period == ssp_clk_slow_period / 2)
                    ssp_clk <= 1'b0;
                // frame rises so the host samples it on a serial clock fall
                if (pos % frame_slow_period == frame_rise)
                    ssp_frame <= 1'b1;
                else if (pos % frame_slow_period == frame_fall)
                    ssp_frame <= 1'b0;
            end

            if (sniffing)
                ssp_din <= byte_q[7];
            else if (mod_type == mode_reader_listen)
            begin
                if (slot_start)
                    ssp_din <= tag_bit;
            end
            else
                ssp_din <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/tag_modulation_detector.sv
/*
  Recovers the tag's load modulation from the sampled carrier.
  A derivative filter finds slopes, the steepest rising and falling slope
  in each 16-cycle window are kept, and a bit is 1 when both exceed the
  threshold. The window is aligned to the expected tag response.
*/
`timescale 1ns/10ps
`default_nettype none

module tag_modulation_detector (
    input  logic                          ck_1356meg,
    input  logic                          fdt_reset,
    input  iso14443a_link_pkg::mode_t     mod_type,
    input  iso14443a_rf_pkg::adc_sample_t adc_d,
    input  logic [10:0]                   edge_detect_threshold,
    reader_sense_if.sink                  sense,
    input  iso14443a_link_pkg::phase_t    phase,
    output logic                          tag_bit
);
    import iso14443a_rf_pkg::*;
    import iso14443a_link_pkg::*;

    adc_sample_t prev_1, prev_2, prev_3, prev_4;
    logic [9:0]  older_sum;
    logic [9:0]  newer_sum;
    filtered_t   filtered;
    filtered_t   threshold;
    filtered_t   pos_max;
    filtered_t   neg_max;
    slot_t       window_time;

    // --------------------------------------------------
    // derivative filter over five samples
    // --------------------------------------------------
    always_ff @(negedge ck_1356meg)
    begin
        prev_4 <= prev_3;
        prev_3 <= prev_2;
        prev_2 <= prev_1;
        prev_1 <= adc_d;
    end

    // weights 2, 1, 0, -1, -2 from oldest to current
    assign older_sum = {1'b0, prev_4, 1'b0} + {2'b00, prev_3};
    assign newer_sum = {1'b0, adc_d, 1'b0} + {2'b00, prev_1};
    assign filtered  = filtered_t'({1'b0, older_sum}) - filtered_t'({1'b0, newer_sum});

    // the host threshold is compared as a signed 11-bit value
    assign threshold = filtered_t'(edge_detect_threshold);

    // window placement, held in every mode except the two below
    always_ff @(negedge ck_1356meg)
    begin
        if (fdt_reset)
            window_time <= listen_window_start;
        else if (mod_type == mode_reader_listen)
            window_time <= listen_window_start;
        // the end of a reader pause predicts when the tag will answer
        else if (mod_type == mode_sniffer && sense.pause_end && sense.reader_active)
            window_time <= phase[3:0] - sniff_window_offset;
    end

    // --------------------------------------------------
    // slope maxima and bit decision per window
    // --------------------------------------------------
    always_ff @(negedge ck_1356meg)
    begin
        if (fdt_reset)
        begin
            pos_max <= '0;
            neg_max <= '0;
            tag_bit <= 1'b0;
        end
        else if (phase[3:0] == window_time)
        begin
            // modulation shows as one steep edge of each sign
            tag_bit <= (pos_max > threshold) && (neg_max < -threshold);
            pos_max <= '0;
            neg_max <= '0;
        end
        else if (filtered > 0)
        begin
            if (filtered > pos_max)
                pos_max <= filtered;
        end
        else if (filtered < neg_max)
            neg_max <= filtered;
    end

endmodule

`default_nettype wire
